// ==== flist.f ====
logic/mbzPkg.sv
logic/memRefIf.sv
logic/memReqCtl.sv
logic/nxmTimer.sv
logic/errorCapture.sv
logic/diagReadout.sv
logic/mbzTop.sv
tb/mbzTop_checker.sv
tb/mbzTb.sv

// ==== tb/mbzTb.sv ====
`timescale 1ns/1ps

module mbzTb;
  import mbzPkg::*;

  localparam int nxmLimit = 16;
  localparam int refBudget = 60;
  localparam int cycleLimit = refBudget * (nxmLimit + 20);

  typedef struct packed {
    logic nxm;
    logic par;
    logic chanNxm;
    eraWord_t era;
    word_t rd;
  } model_t;

  logic clk;
  logic rst;
  logic ebusReq;
  logic chanReq;
  logic reqWrite;
  physAddr_t reqAddr;
  logic memAck;
  word_t memData;
  logic memParity;
  logic errClr;
  logic diagRead;
  diagSel_t diagSel;
  logic memStart;
  physAddr_t memAddr;
  logic memWrite;
  logic coreBusy;
  logic nxmDataValid;
  word_t diagWord;

  // Current reference as seen by the responder and the compare process
  model_t expModel;
  string testName;
  physAddr_t planAddr;
  logic planWrite;
  logic planWithhold;
  int planDelay;
  word_t planData;
  logic planParity;
  logic expDataValid;
  int doneCount;
  int errCount;
  int cycleCnt;
  logic [31:0] lfsrState;

  mbzTop #(
    .nxmLimit(nxmLimit)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .ebusReq(ebusReq),
    .chanReq(chanReq),
    .reqWrite(reqWrite),
    .reqAddr(reqAddr),
    .memAck(memAck),
    .memData(memData),
    .memParity(memParity),
    .errClr(errClr),
    .diagRead(diagRead),
    .diagSel(diagSel),
    .memStart(memStart),
    .memAddr(memAddr),
    .memWrite(memWrite),
    .coreBusy(coreBusy),
    .nxmDataValid(nxmDataValid),
    .diagData(diagWord)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic failRun(string why);
    errCount++;
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkWord(string name, word_t expVal, word_t actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("Fail %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkEra(string name, eraWord_t expVal, eraWord_t actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("Fail %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkAddr(string name, physAddr_t expVal, physAddr_t actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("Fail %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkBit(string name, logic expVal, logic actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("Fail %s: expected %b, actual %b", name, expVal, actVal));
    end
  endtask

  task automatic checkCount(string name, int expVal, int actVal);
    if (actVal != expVal) begin
      failRun($sformatf("Fail %s: expected %0d, actual %0d", name, expVal, actVal));
    end
  endtask

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [35:0] takeBits(int n);
    logic [35:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[34:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Expected board state after one finished reference
  function automatic model_t nextModel(model_t cur, logic wr, logic chan, physAddr_t addr,
                                       logic acked, word_t data, logic par);
    model_t nxt;
    logic parBad;
    logic newErr;
    nxt = cur;
    parBad = acked && !wr && (($countones({data, par}) % 2) == 0);
    newErr = parBad || !acked;
    if (acked && !wr) begin
      nxt.rd = data;
    end
    if (newErr && !(cur.nxm || cur.par || cur.chanNxm)) begin
      nxt.era = {wr, chan, addr};
    end
    if (parBad) begin
      nxt.par = 1'b1;
    end
    if (!acked) begin
      nxt.nxm = 1'b1;
      nxt.chanNxm = cur.chanNxm | chan;
    end
    return nxt;
  endfunction

  task automatic readBack(string name);
    diagRead <= 1'b1;
    diagSel <= diagStatus;
    @(posedge clk);
    checkWord({name, " status"},
              {32'd0, 1'b0, expModel.nxm, expModel.par, expModel.chanNxm}, diagWord);
    diagSel <= diagEra;
    @(posedge clk);
    checkEra({name, " era"}, expModel.era, diagWord[23:0]);
    checkBit({name, " era upper bits"}, 1'b0, |diagWord[35:24]);
    diagSel <= diagData;
    @(posedge clk);
    checkWord({name, " read word"}, expModel.rd, diagWord);
    diagSel <= diagNone;
    @(posedge clk);
    checkWord({name, " none select"}, '0, diagWord);
    diagRead <= 1'b0;
    diagSel <= diagStatus;
    @(posedge clk);
    checkWord({name, " bus idle"}, '0, diagWord);
  endtask

  task automatic clearErrors();
    @(posedge clk);
    errClr <= 1'b1;
    @(posedge clk);
    errClr <= 1'b0;
    expModel.nxm = 1'b0;
    expModel.par = 1'b0;
    expModel.chanNxm = 1'b0;
  endtask

  task automatic runRef(string name, logic chan, logic ebus, logic wr, physAddr_t addr,
                        logic withhold, int delay, logic goodPar, logic busyReq);
    word_t data;
    int target;
    data = takeBits(36);
    testName = name;
    planAddr = addr;
    planWrite = wr;
    planWithhold = withhold;
    planDelay = delay;
    planData = data;
    planParity = goodPar ? ~(^data) : ^data;
    expDataValid = withhold && !wr;
    expModel = nextModel(expModel, wr, chan, addr, !withhold, data, planParity);
    target = doneCount + 1;
    @(posedge clk);
    chanReq <= chan;
    ebusReq <= ebus;
    reqWrite <= wr;
    reqAddr <= addr;
    @(posedge clk);
    chanReq <= 1'b0;
    ebusReq <= 1'b0;
    // Extra request lands while the reference is still open
    if (busyReq) begin
      repeat (2) @(posedge clk);
      ebusReq <= 1'b1;
      reqAddr <= ~addr;
      reqWrite <= ~wr;
      @(posedge clk);
      ebusReq <= 1'b0;
    end
    wait (doneCount == target);
  endtask

  // Memory responder
  initial begin : responder
    int waitCnt;
    memAck <= 1'b0;
    memData <= '0;
    memParity <= 1'b0;
    forever begin
      @(posedge clk);
      if (memStart) begin
        checkAddr({testName, " memAddr"}, planAddr, memAddr);
        checkBit({testName, " memWrite"}, planWrite, memWrite);
        memData <= planData;
        memParity <= planParity;
        if (!planWithhold) begin
          for (waitCnt = 1; waitCnt < planDelay; waitCnt++) begin
            @(posedge clk);
          end
          memAck <= 1'b1;
          @(posedge clk);
          memAck <= 1'b0;
        end
      end
    end
  end

  // Compare process runs once after reset and at every end of a reference
  initial begin : compare
    logic busyWas;
    int startCount;
    int dvCount;
    diagRead <= 1'b0;
    diagSel <= diagNone;
    busyWas = 1'b0;
    startCount = 0;
    dvCount = 0;
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    checkBit("reset memStart", 1'b0, memStart);
    checkBit("reset coreBusy", 1'b0, coreBusy);
    checkBit("reset nxmDataValid", 1'b0, nxmDataValid);
    readBack("reset");
    doneCount++;
    forever begin
      @(posedge clk);
      if (memStart) begin
        startCount++;
      end
      if (nxmDataValid) begin
        dvCount++;
      end
      if (busyWas && !coreBusy) begin
        checkCount({testName, " memStart pulses"}, 1, startCount);
        checkCount({testName, " nxmDataValid pulses"}, expDataValid ? 1 : 0, dvCount);
        readBack(testName);
        startCount = 0;
        dvCount = 0;
        doneCount++;
      end
      busyWas = coreBusy;
    end
  end

  // Timing assertions in the bound checker
  initial begin : assertWatch
    wait (UUT.timingChk.failCount != 0);
    failRun("A timing assertion in the bound checker failed");
  end

  initial begin : cycleWatch
    cycleCnt = 0;
    forever begin
      @(posedge clk);
      cycleCnt++;
      if (cycleCnt >= cycleLimit) begin
        failRun($sformatf("Timeout after %0d cycles, the DUT never finished a reference",
                          cycleLimit));
      end
    end
  end

  initial begin : stimulus
    physAddr_t addr;
    logic wr;
    logic chan;
    logic ebus;
    logic withhold;
    logic goodPar;
    int delay;
    lfsrState = 32'h4f30;
    expModel = '0;
    doneCount = 0;
    errCount = 0;
    testName = "reset";
    planAddr = '0;
    planWrite = 1'b0;
    planWithhold = 1'b1;
    planDelay = 1;
    planData = '0;
    planParity = 1'b0;
    expDataValid = 1'b0;
    rst <= 1'b1;
    ebusReq <= 1'b0;
    chanReq <= 1'b0;
    reqWrite <= 1'b0;
    reqAddr <= '0;
    errClr <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (doneCount == 1);

    // Clean references from either source
    for (int i = 0; i < 8; i++) begin
      chan = 1'(takeBits(1));
      wr = 1'(takeBits(1));
      addr = physAddr_t'(takeBits(22));
      delay = int'(takeBits(4)) % 10 + 1;
      runRef($sformatf("good ref %0d", i), chan, !chan, wr, addr, 1'b0, delay, 1'b1, 1'b0);
    end

    // First error holds the error address
    runRef("bad parity", 1'b0, 1'b1, 1'b0, 22'h12345, 1'b0, 3, 1'b0, 1'b0);
    runRef("second bad parity", 1'b0, 1'b1, 1'b0, 22'h2abcd, 1'b0, 5, 1'b0, 1'b0);
    runRef("nxm before clear", 1'b1, 1'b0, 1'b1, 22'h3f001, 1'b1, 1, 1'b1, 1'b0);
    clearErrors();
    runRef("good after clear", 1'b0, 1'b1, 1'b0, 22'h00777, 1'b0, 2, 1'b1, 1'b0);
    runRef("nxm read", 1'b0, 1'b1, 1'b0, 22'h1c0de, 1'b1, 1, 1'b1, 1'b0);
    clearErrors();
    runRef("chan nxm write", 1'b1, 1'b0, 1'b1, 22'h2beef, 1'b1, 1, 1'b1, 1'b0);
    clearErrors();
    runRef("chan wins tie", 1'b1, 1'b1, 1'b0, 22'h05a5a, 1'b1, 1, 1'b1, 1'b0);
    clearErrors();
    runRef("request while busy", 1'b0, 1'b1, 1'b0, 22'h13579, 1'b0, 8, 1'b1, 1'b1);

    // Random mix with occasional clears
    for (int i = 0; i < 24; i++) begin
      chan = 1'(takeBits(1));
      ebus = !chan || 1'(takeBits(1));
      wr = 1'(takeBits(1));
      addr = physAddr_t'(takeBits(22));
      withhold = (takeBits(3) == 0);
      goodPar = (takeBits(2) != 0);
      delay = int'(takeBits(4)) % 10 + 1;
      runRef($sformatf("random ref %0d", i), chan, ebus, wr, addr, withhold, delay,
             goodPar, 1'b0);
      if (takeBits(3) == 0) begin
        clearErrors();
      end
    end

    repeat (2) @(posedge clk);
    if (errCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/mbzTop_checker.sv ====
`timescale 1ns/1ps

module mbzTopChecker (
  input logic clk,
  input logic rst,
  input logic memStart,
  input logic coreBusy,
  input logic memWrite,
  input logic nxmDataValid
);

  // Assertion failures seen so far
  int failCount;

  initial begin
    failCount = 0;
  end

  // Start is a single-cycle pulse
  startOneCycle: assert property (@(posedge clk) disable iff (rst) memStart |=> !memStart)
    else begin
      $error("memStart stayed high for more than one cycle");
      failCount++;
    end

  // Busy must still be up the cycle after start
  startThenBusy: assert property (@(posedge clk) disable iff (rst) memStart |=> coreBusy)
    else begin
      $error("coreBusy was low in the cycle after memStart");
      failCount++;
    end

  // Substitute data valid only for reads
  noValidOnWrite: assert property (@(posedge clk) disable iff (rst) nxmDataValid |-> !memWrite)
    else begin
      $error("nxmDataValid pulsed during a write reference");
      failCount++;
    end

endmodule

bind mbzTop mbzTopChecker timingChk (
  .clk(clk),
  .rst(rst),
  .memStart(memStart),
  .coreBusy(coreBusy),
  .memWrite(memWrite),
  .nxmDataValid(nxmDataValid)
);

// ==== logic/mbzTop.sv ====
`timescale 1ns/1ps

module mbzTop #(
  parameter int nxmLimit = 16
) (
  input logic clk,
  input logic rst,
  input logic ebusReq,
  input logic chanReq,
  input logic reqWrite,
  input mbzPkg::physAddr_t reqAddr,
  input logic memAck,
  input mbzPkg::word_t memData,
  input logic memParity,
  input logic errClr,
  input logic diagRead,
  input mbzPkg::diagSel_t diagSel,
  output logic memStart,
  output mbzPkg::physAddr_t memAddr,
  output logic memWrite,
  output logic coreBusy,
  output logic nxmDataValid,
  output mbzPkg::word_t diagData
);
  import mbzPkg::*;

  logic nxmErr;
  logic parErr;
  logic chanNxmErr;
  eraWord_t errAddr;
  word_t readWord;

  memRefIf memRef ();

  memReqCtl reqCtl (
    .clk(clk),
    .rst(rst),
    .ebusReq(ebusReq),
    .chanReq(chanReq),
    .reqWrite(reqWrite),
    .reqAddr(reqAddr),
    .memRef(memRef.ctl),
    .memStart(memStart),
    .coreBusy(coreBusy)
  );

  nxmTimer #(
    .nxmLimit(nxmLimit)
  ) watchdog (
    .clk(clk),
    .rst(rst),
    .memAck(memAck),
    .memRef(memRef.timer),
    .nxmDataValid(nxmDataValid)
  );

  errorCapture errCap (
    .clk(clk),
    .rst(rst),
    .memData(memData),
    .memParity(memParity),
    .errClr(errClr),
    .memRef(memRef.capture),
    .nxmErr(nxmErr),
    .parErr(parErr),
    .chanNxmErr(chanNxmErr),
    .errAddr(errAddr),
    .readWord(readWord)
  );

  diagReadout readout (
    .diagRead(diagRead),
    .diagSel(diagSel),
    .coreBusy(coreBusy),
    .nxmErr(nxmErr),
    .parErr(parErr),
    .chanNxmErr(chanNxmErr),
    .errAddr(errAddr),
    .readWord(readWord),
    .diagData(diagData)
  );

  // Address and direction go to memory straight from the open reference
  assign memAddr = memRef.refAddr;
  assign memWrite = memRef.refWrite;

endmodule

// ==== logic/diagReadout.sv ====
`timescale 1ns/1ps

module diagReadout (
  input logic diagRead,
  input mbzPkg::diagSel_t diagSel,
  input logic coreBusy,
  input logic nxmErr,
  input logic parErr,
  input logic chanNxmErr,
  input mbzPkg::eraWord_t errAddr,
  input mbzPkg::word_t readWord,
  output mbzPkg::word_t diagData
);
  import mbzPkg::*;

  word_t statusWord;
  word_t eraWord;

  always_comb begin
    statusWord = '0;
    statusWord[3:0] = {coreBusy, nxmErr, parErr, chanNxmErr};
    eraWord = word_t'(errAddr);
  end

  // Select literals are scoped since the output port shares a name with one
  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        mbzPkg::diagStatus: diagData = statusWord;
        mbzPkg::diagEra: diagData = eraWord;
        mbzPkg::diagData: diagData = readWord;
        mbzPkg::diagNone: diagData = '0;
        default: diagData = '0;
      endcase
    end
  end

endmodule

// ==== logic/errorCapture.sv ====
`timescale 1ns/1ps

module errorCapture (
  input logic clk,
  input logic rst,
  input mbzPkg::word_t memData,
  input logic memParity,
  input logic errClr,
  memRefIf.capture memRef,
  output logic nxmErr,
  output logic parErr,
  output logic chanNxmErr,
  output mbzPkg::eraWord_t errAddr,
  output mbzPkg::word_t readWord
);
  import mbzPkg::*;

  logic readAck;
  logic badParity;
  logic newNxm;
  logic newPar;
  logic newErr;
  logic anyFlag;
  logic eraLoad;
  eraWord_t eraIn;

  always_comb begin
    readAck = memRef.refDone & memRef.refAck & ~memRef.refWrite;
    // Odd parity over the data word and its parity bit
    badParity = ~(^{memData, memParity});
    newPar = readAck & badParity;
    newNxm = memRef.refDone & memRef.refNxm;
    newErr = newPar | newNxm;
    anyFlag = nxmErr | parErr | chanNxmErr;
    // First error wins until errClr
    eraLoad = newErr & (~anyFlag | errClr);
    eraIn = {memRef.refWrite, memRef.refChan, memRef.refAddr};
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (rst) begin
      nxmErr <= 1'b0;
      parErr <= 1'b0;
      chanNxmErr <= 1'b0;
    end else begin
      if (errClr) begin
        nxmErr <= 1'b0;
        parErr <= 1'b0;
        chanNxmErr <= 1'b0;
      end
      // A new error in the clear cycle still sets its flag
      if (newNxm) begin
        nxmErr <= 1'b1;
      end
      if (newNxm && memRef.refChan) begin
        chanNxmErr <= 1'b1;
      end
      if (newPar) begin
        parErr <= 1'b1;
      end
    end
  end

  // Error address, errClr leaves it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      errAddr <= '0;
    end else if (eraLoad) begin
      errAddr <= eraIn;
    end
  end

  // Last word read back
  always_ff @(posedge clk) begin
    if (rst) begin
      readWord <= '0;
    end else if (readAck) begin
      readWord <= memData;
    end
  end

endmodule

// ==== logic/nxmTimer.sv ====
`timescale 1ns/1ps

module nxmTimer #(
  parameter int nxmLimit = 16
) (
  input logic clk,
  input logic rst,
  input logic memAck,
  memRefIf.timer memRef,
  output logic nxmDataValid
);

  // Count value seen on the edge that ends the nxmLimit-th cycle
  localparam logic [7:0] lastCount = 8'(nxmLimit - 1);

  logic refOpen;
  logic [7:0] watchCnt;
  logic refLive;
  logic timeUp;
  logic ackHit;
  logic ackPulse;
  logic nxmPulse;
  logic donePulse;

  // Reference counts as open already during its start cycle
  assign refLive = memRef.refStart | refOpen;
  assign timeUp = refOpen && (watchCnt == lastCount);
  // A late acknowledge loses to the timeout
  assign ackHit = refLive & memAck & ~timeUp;

  always_ff @(posedge clk) begin
    if (rst) begin
      refOpen <= 1'b0;
      watchCnt <= 8'd0;
    end else if (ackHit || timeUp) begin
      refOpen <= 1'b0;
      watchCnt <= 8'd0;
    end else if (memRef.refStart) begin
      refOpen <= 1'b1;
      watchCnt <= 8'd1;
    end else if (refOpen) begin
      watchCnt <= watchCnt + 8'd1;
    end
  end

  // Completion pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      ackPulse <= 1'b0;
      nxmPulse <= 1'b0;
      donePulse <= 1'b0;
      nxmDataValid <= 1'b0;
    end else begin
      ackPulse <= ackHit;
      nxmPulse <= timeUp;
      donePulse <= ackHit | timeUp;
      // Substitute data valid so a stalled read can finish
      nxmDataValid <= timeUp & ~memRef.refWrite;
    end
  end

  assign memRef.refAck = ackPulse;
  assign memRef.refNxm = nxmPulse;
  assign memRef.refDone = donePulse;

endmodule

// ==== logic/memReqCtl.sv ====
`timescale 1ns/1ps

module memReqCtl (
  input logic clk,
  input logic rst,
  input logic ebusReq,
  input logic chanReq,
  input logic reqWrite,
  input mbzPkg::physAddr_t reqAddr,
  memRefIf.ctl memRef,
  output logic memStart,
  output logic coreBusy
);
  import mbzPkg::*;

  refState_t state;
  logic startPulse;
  physAddr_t addrReg;
  logic writeReg;
  logic chanReg;
  logic anyReq;

  assign anyReq = ebusReq | chanReq;

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      startPulse <= 1'b0;
      coreBusy <= 1'b0;
    end else begin
      case (state)
        idle: begin
          startPulse <= 1'b0;
          if (anyReq) begin
            state <= start;
          end
        end
        start: begin
          // Start pulse and busy rise together
          startPulse <= 1'b1;
          coreBusy <= 1'b1;
          state <= busy;
        end
        busy: begin
          startPulse <= 1'b0;
          if (memRef.refDone) begin
            coreBusy <= 1'b0;
            state <= idle;
          end
        end
        default: begin
          startPulse <= 1'b0;
          coreBusy <= 1'b0;
          state <= idle;
        end
      endcase
    end
  end

  // Reference attributes, held until the next accepted request
  always_ff @(posedge clk) begin
    if (state == idle && anyReq) begin
      addrReg <= reqAddr;
      writeReg <= reqWrite;
      // Channel wins a tie with the EBOX
      chanReg <= chanReq;
    end
  end

  assign memRef.refStart = startPulse;
  assign memRef.refAddr = addrReg;
  assign memRef.refWrite = writeReg;
  assign memRef.refChan = chanReg;

  assign memStart = startPulse;

endmodule

// ==== logic/memRefIf.sv ====
`timescale 1ns/1ps

interface memRefIf;
  import mbzPkg::*;

  // Reference start and its attributes
  logic refStart;
  physAddr_t refAddr;
  logic refWrite;
  logic refChan;

  // Completion, refDone comes with either refAck or refNxm
  logic refAck;
  logic refNxm;
  logic refDone;

  modport ctl (
    output refStart, refAddr, refWrite, refChan,
    input refDone
  );

  modport timer (
    input refStart, refWrite,
    output refAck, refNxm, refDone
  );

  modport capture (
    input refStart, refAddr, refWrite, refChan,
    input refAck, refNxm, refDone
  );

endinterface

// ==== logic/mbzPkg.sv ====
package mbzPkg;

  // Memory data word, bit 35 is the leftmost bit of the 36-bit word
  typedef logic [35:0] word_t;

  // Physical memory address
  typedef logic [21:0] physAddr_t;

  // Error address register
  // {write, channel, address}
  typedef logic [23:0] eraWord_t;

  // Diagnostic readout select
  typedef enum logic [1:0] {
    diagStatus = 2'd0,
    diagEra    = 2'd1,
    diagData   = 2'd2,
    diagNone   = 2'd3
  } diagSel_t;

  // Request controller states
  typedef enum logic [1:0] {
    idle  = 2'd0,
    start = 2'd1,
    busy  = 2'd2
  } refState_t;

endpackage
